// ==== hw/arb_params.svh ====
`ifndef ARB_PARAMS_SVH
`define ARB_PARAMS_SVH

// --------------------
// client count and field widths
// --------------------
`define ARB_NUM_CLIENTS 4     // identical clients behind the arbiter
`define ARB_CLIENT_W    2     // client number, upper tid bits
`define ARB_TAG_W       6     // client local tag, lower tid bits
`define ARB_ADDR_W      32    // cache-line address
`define ARB_DATA_W      64    // line data, reduced from full line

`endif

// ==== hw/arb_pkg.sv ====
`include "arb_params.svh"

package arb_pkg;

   // --------------------
   // plain vectors
   // --------------------
   typedef logic [`ARB_ADDR_W-1:0]              addr_t;       // line address
   typedef logic [`ARB_DATA_W-1:0]              data_t;       // line data
   typedef logic [`ARB_TAG_W-1:0]               tag_t;        // client local tag
   typedef logic [`ARB_CLIENT_W-1:0]            client_id_t;  // client number
   typedef logic [`ARB_CLIENT_W+`ARB_TAG_W-1:0] tid_t;        // client over tag

   // --------------------
   // client side
   // --------------------
   typedef struct packed {
      addr_t offset;    // relative to read base
      tag_t  tag;
   } rd_req_t;

   typedef struct packed {
      addr_t offset;    // relative to write base
      tag_t  tag;
      data_t data;
   } wr_req_t;

   typedef struct packed {
      tag_t  tag;
      addr_t addr;      // host address recorded at accept
      data_t data;
   } rd_rsp_t;

   typedef struct packed {
      tag_t  tag;
      addr_t addr;
   } wr_rsp_t;

   // --------------------
   // host side
   // --------------------
   typedef struct packed {
      addr_t addr;      // base already added
      tid_t  tid;
   } host_rd_req_t;

   typedef struct packed {
      addr_t addr;
      tid_t  tid;
      data_t data;
   } host_wr_req_t;

   typedef struct packed {
      tid_t  tid;
      data_t data;
   } host_rd_rsp_t;

   typedef struct packed {
      tid_t  tid;
   } host_wr_rsp_t;

endpackage

// ==== hw/fair_arbiter.sv ====
module fair_arbiter #(
   parameter int num_inputs = 2                       // two or more
) (
   input  logic                  Clk_32UI,
   input  logic                  reset_n,
   input  logic [num_inputs-1:0] in_valid,            // one request bit per input
   input  logic                  accept,              // host took the granted request
   output arb_pkg::client_id_t   out_select,          // granted input
   output logic                  out_valid            // any input requesting
);

   import arb_pkg::*;

   logic [num_inputs-1:0] upper_mask;                 // inputs above last grant
   logic [num_inputs-1:0] upper_in;                   // first priority half
   logic [num_inputs-1:0] lower_in;                   // last grant and below
   client_id_t            upper_sel;
   client_id_t            lower_sel;

   // --------------------
   // split mask, moves only on accept
   // --------------------
   always_ff @(posedge Clk_32UI)
   begin
      if (!reset_n)
      begin
         upper_mask <= '1;                            // input 0 first after reset
      end
      else if (accept)
      begin
         upper_mask <= {{(num_inputs-1){1'b1}}, 1'b0} << out_select;  // bits above grant
      end
   end

   assign upper_in = in_valid & upper_mask;
   assign lower_in = in_valid & ~upper_mask;

   // lowest index in each half, scanned from the top down
   always_comb
   begin
      upper_sel = '0;
      lower_sel = '0;
      for (int i = num_inputs-1; i >= 0; i--)
      begin
         if (upper_in[i])
         begin
            upper_sel = client_id_t'(i);
         end
         if (lower_in[i])
         begin
            lower_sel = client_id_t'(i);
         end
      end
   end

   assign out_select = (|upper_in) ? upper_sel : lower_sel;   // upper half wins
   assign out_valid  = |in_valid;

   // grant must always point at a live request, whatever the mask history
   a_select_valid : assert property (@(posedge Clk_32UI) disable iff (!reset_n)
      out_valid |-> in_valid[out_select]);

endmodule

// ==== hw/read_path.sv ====
`include "arb_params.svh"

module read_path (
   input  logic                          Clk_32UI,
   input  logic                          reset_n,
   input  arb_pkg::rd_req_t              rd_req [`ARB_NUM_CLIENTS],   // held until sent
   input  logic [`ARB_NUM_CLIENTS-1:0]   rd_en,
   output logic [`ARB_NUM_CLIENTS-1:0]   rd_sent,
   input  arb_pkg::addr_t                read_base,
   output arb_pkg::host_rd_req_t         host_rd_req,
   output logic                          host_rd_en,
   input  logic                          host_rd_sent,
   input  arb_pkg::tid_t                 lookup_tid,                  // from response router
   output arb_pkg::addr_t                lookup_addr                  // one cycle after tid
);

   import arb_pkg::*;

   localparam int mem_depth = 1 << $bits(tid_t);   // one slot per host id

   client_id_t grant;
   logic       grant_valid;
   logic       accept;                             // en and sent at the same edge
   rd_req_t    sel_req;
   addr_t      tag_mem [mem_depth];                // host address per outstanding id

   // --------------------
   // grant selection
   // --------------------
   fair_arbiter #(
      .num_inputs (`ARB_NUM_CLIENTS)
   ) u_fair_arbiter (
      .Clk_32UI   (Clk_32UI),
      .reset_n    (reset_n),
      .in_valid   (rd_en),
      .accept     (accept),
      .out_select (grant),
      .out_valid  (grant_valid)
   );

   assign sel_req    = rd_req[grant];               // granted client's request
   assign host_rd_en = grant_valid;                 // same cycle as client en
   assign accept     = host_rd_en & host_rd_sent;

   always_comb
   begin
      host_rd_req.addr = read_base + sel_req.offset;   // offset into read region
      host_rd_req.tid  = {grant, sel_req.tag};         // client number on top
   end

   // sent goes back to the granted client only
   always_comb
   begin
      rd_sent        = '0;
      rd_sent[grant] = grant_valid & host_rd_sent;
   end

   // --------------------
   // tag memory
   // --------------------
   always_ff @(posedge Clk_32UI)
   begin
      if (accept)
      begin
         tag_mem[host_rd_req.tid] <= host_rd_req.addr;   // record under host id
      end
      lookup_addr <= tag_mem[lookup_tid];                // sync read
   end

   // sent reaches at most one client, and only one that is asking
   a_rd_sent_onehot : assert property (@(posedge Clk_32UI) disable iff (!reset_n)
      $onehot0(rd_sent) && ((rd_sent & ~rd_en) == '0));

endmodule

// ==== hw/write_path.sv ====
`include "arb_params.svh"

module write_path (
   input  logic                          Clk_32UI,
   input  logic                          reset_n,
   input  arb_pkg::wr_req_t              wr_req [`ARB_NUM_CLIENTS],   // held until sent
   input  logic [`ARB_NUM_CLIENTS-1:0]   wr_en,
   output logic [`ARB_NUM_CLIENTS-1:0]   wr_sent,
   input  arb_pkg::addr_t                write_base,
   output arb_pkg::host_wr_req_t         host_wr_req,
   output logic                          host_wr_en,
   input  logic                          host_wr_sent,
   input  arb_pkg::tid_t                 lookup_tid,                  // from response router
   output arb_pkg::addr_t                lookup_addr                  // one cycle after tid
);

   import arb_pkg::*;

   localparam int mem_depth = 1 << $bits(tid_t);   // one slot per host id

   client_id_t grant;
   logic       grant_valid;
   logic       accept;                             // write taken by host
   wr_req_t    sel_req;
   addr_t      tag_mem [mem_depth];

   // --------------------
   // grant selection
   // --------------------
   fair_arbiter #(
      .num_inputs (`ARB_NUM_CLIENTS)
   ) u_fair_arbiter (
      .Clk_32UI   (Clk_32UI),
      .reset_n    (reset_n),
      .in_valid   (wr_en),
      .accept     (accept),
      .out_select (grant),
      .out_valid  (grant_valid)
   );

   assign sel_req    = wr_req[grant];
   assign host_wr_en = grant_valid;
   assign accept     = host_wr_en & host_wr_sent;

   always_comb
   begin
      host_wr_req.addr = write_base + sel_req.offset;  // offset into write region
      host_wr_req.tid  = {grant, sel_req.tag};
      host_wr_req.data = sel_req.data;                 // line data passes through
   end

   // route sent to the granted writer
   always_comb
   begin
      wr_sent        = '0;
      wr_sent[grant] = grant_valid & host_wr_sent;
   end

   // --------------------
   // tag memory
   // --------------------
   always_ff @(posedge Clk_32UI)
   begin
      if (accept)
      begin
         tag_mem[host_wr_req.tid] <= host_wr_req.addr;
      end
      lookup_addr <= tag_mem[lookup_tid];              // ready with the registered rsp
   end

   // one writer at most, and it must be requesting
   a_wr_sent_onehot : assert property (@(posedge Clk_32UI) disable iff (!reset_n)
      $onehot0(wr_sent) && ((wr_sent & ~wr_en) == '0));

endmodule

// ==== hw/response_router.sv ====
`include "arb_params.svh"

module response_router (
   input  logic                          Clk_32UI,
   input  logic                          reset_n,
   input  logic                          host_rd_rsp_valid,   // single-cycle pulse
   input  arb_pkg::host_rd_rsp_t         host_rd_rsp,
   input  logic                          host_wr_rsp_valid,
   input  arb_pkg::host_wr_rsp_t         host_wr_rsp,
   output arb_pkg::tid_t                 rd_lookup_tid,       // to read tag memory
   input  arb_pkg::addr_t                rd_lookup_addr,
   output arb_pkg::tid_t                 wr_lookup_tid,       // to write tag memory
   input  arb_pkg::addr_t                wr_lookup_addr,
   output logic [`ARB_NUM_CLIENTS-1:0]   rd_rsp_valid,
   output arb_pkg::rd_rsp_t              rd_rsp [`ARB_NUM_CLIENTS],
   output logic [`ARB_NUM_CLIENTS-1:0]   wr_rsp_valid,
   output arb_pkg::wr_rsp_t              wr_rsp [`ARB_NUM_CLIENTS]
);

   import arb_pkg::*;

   logic         rd_valid_q;
   host_rd_rsp_t rd_q;                                 // payload, no reset
   logic         wr_valid_q;
   host_wr_rsp_t wr_q;
   client_id_t   rd_client;                            // decoded from tid top bits
   client_id_t   wr_client;

   // lookup starts in the host cycle so the address lines up with the register
   assign rd_lookup_tid = host_rd_rsp.tid;
   assign wr_lookup_tid = host_wr_rsp.tid;

   // --------------------
   // response register stage
   // --------------------
   always_ff @(posedge Clk_32UI)
   begin
      if (!reset_n)
      begin
         rd_valid_q <= 1'b0;
         wr_valid_q <= 1'b0;
      end
      else
      begin
         rd_valid_q <= host_rd_rsp_valid;
         wr_valid_q <= host_wr_rsp_valid;
      end
      rd_q <= host_rd_rsp;                             // captured every cycle
      wr_q <= host_wr_rsp;
   end

   assign rd_client = rd_q.tid[$bits(tid_t)-1 -: `ARB_CLIENT_W];
   assign wr_client = wr_q.tid[$bits(tid_t)-1 -: `ARB_CLIENT_W];

   // --------------------
   // steering to clients
   // --------------------
   always_comb
   begin
      for (int c = 0; c < `ARB_NUM_CLIENTS; c++)
      begin
         rd_rsp_valid[c] = rd_valid_q & (rd_client == client_id_t'(c));  // named client only
         rd_rsp[c].tag   = rd_q.tid[`ARB_TAG_W-1:0];
         rd_rsp[c].addr  = rd_lookup_addr;             // shared payload
         rd_rsp[c].data  = rd_q.data;
         wr_rsp_valid[c] = wr_valid_q & (wr_client == client_id_t'(c));
         wr_rsp[c].tag   = wr_q.tid[`ARB_TAG_W-1:0];
         wr_rsp[c].addr  = wr_lookup_addr;
      end
   end

   // host ids must name a client that exists
   a_rd_client_range : assert property (@(posedge Clk_32UI) disable iff (!reset_n)
      rd_valid_q |-> (int'(rd_client) < `ARB_NUM_CLIENTS));

   a_wr_client_range : assert property (@(posedge Clk_32UI) disable iff (!reset_n)
      wr_valid_q |-> (int'(wr_client) < `ARB_NUM_CLIENTS));

endmodule

// ==== hw/request_arbiter.sv ====
`include "arb_params.svh"

module request_arbiter (
   input  logic                          Clk_32UI,
   input  logic                          reset_n,
   // --------------------
   // client side
   input  arb_pkg::rd_req_t              rd_req [`ARB_NUM_CLIENTS],
   input  logic [`ARB_NUM_CLIENTS-1:0]   rd_en,
   output logic [`ARB_NUM_CLIENTS-1:0]   rd_sent,
   input  arb_pkg::wr_req_t              wr_req [`ARB_NUM_CLIENTS],
   input  logic [`ARB_NUM_CLIENTS-1:0]   wr_en,
   output logic [`ARB_NUM_CLIENTS-1:0]   wr_sent,
   output logic [`ARB_NUM_CLIENTS-1:0]   rd_rsp_valid,
   output arb_pkg::rd_rsp_t              rd_rsp [`ARB_NUM_CLIENTS],
   output logic [`ARB_NUM_CLIENTS-1:0]   wr_rsp_valid,
   output arb_pkg::wr_rsp_t              wr_rsp [`ARB_NUM_CLIENTS],
   input  arb_pkg::addr_t                read_base,      // read region start
   input  arb_pkg::addr_t                write_base,     // write region start
   // --------------------
   // host side
   output arb_pkg::host_rd_req_t         host_rd_req,
   output logic                          host_rd_en,
   input  logic                          host_rd_sent,
   output arb_pkg::host_wr_req_t         host_wr_req,
   output logic                          host_wr_en,
   input  logic                          host_wr_sent,
   input  logic                          host_rd_rsp_valid,
   input  arb_pkg::host_rd_rsp_t         host_rd_rsp,
   input  logic                          host_wr_rsp_valid,
   input  arb_pkg::host_wr_rsp_t         host_wr_rsp
);

   import arb_pkg::*;

   tid_t  rd_lookup_tid;                    // router to read tag memory
   addr_t rd_lookup_addr;
   tid_t  wr_lookup_tid;                    // router to write tag memory
   addr_t wr_lookup_addr;

   read_path u_read_path (
      .Clk_32UI     (Clk_32UI),
      .reset_n      (reset_n),
      .rd_req       (rd_req),
      .rd_en        (rd_en),
      .rd_sent      (rd_sent),
      .read_base    (read_base),
      .host_rd_req  (host_rd_req),
      .host_rd_en   (host_rd_en),
      .host_rd_sent (host_rd_sent),
      .lookup_tid   (rd_lookup_tid),
      .lookup_addr  (rd_lookup_addr)
   );

   write_path u_write_path (
      .Clk_32UI     (Clk_32UI),
      .reset_n      (reset_n),
      .wr_req       (wr_req),
      .wr_en        (wr_en),
      .wr_sent      (wr_sent),
      .write_base   (write_base),
      .host_wr_req  (host_wr_req),
      .host_wr_en   (host_wr_en),
      .host_wr_sent (host_wr_sent),
      .lookup_tid   (wr_lookup_tid),
      .lookup_addr  (wr_lookup_addr)
   );

   response_router u_response_router (
      .Clk_32UI          (Clk_32UI),
      .reset_n           (reset_n),
      .host_rd_rsp_valid (host_rd_rsp_valid),
      .host_rd_rsp       (host_rd_rsp),
      .host_wr_rsp_valid (host_wr_rsp_valid),
      .host_wr_rsp       (host_wr_rsp),
      .rd_lookup_tid     (rd_lookup_tid),
      .rd_lookup_addr    (rd_lookup_addr),
      .wr_lookup_tid     (wr_lookup_tid),
      .wr_lookup_addr    (wr_lookup_addr),
      .rd_rsp_valid      (rd_rsp_valid),
      .rd_rsp            (rd_rsp),
      .wr_rsp_valid      (wr_rsp_valid),
      .wr_rsp            (wr_rsp)
   );

endmodule

// ==== verif/tb_request_arbiter.sv ====
`include "arb_params.svh"

module tb_request_arbiter;

   timeunit 1ns;
   timeprecision 1ps;

   import arb_pkg::*;

   localparam int n         = `ARB_NUM_CLIENTS;
   localparam int num_rsp   = 150;                       // responses per direction
   localparam int max_out   = 8;                         // open ids per client, tags never reused
   localparam int run_limit = 20000;                     // cycles per wait loop
   localparam logic [n-1:0] lsb_one = {{(n-1){1'b0}}, 1'b1};

   // --------------------
   // DUT ports
   // --------------------
   logic          Clk_32UI          = 1'b0;
   logic          reset_n           = 1'b0;
   rd_req_t       rd_req [n]        = '{default: '0};
   logic [n-1:0]  rd_en             = '0;
   logic [n-1:0]  rd_sent;
   wr_req_t       wr_req [n]        = '{default: '0};
   logic [n-1:0]  wr_en             = '0;
   logic [n-1:0]  wr_sent;
   logic [n-1:0]  rd_rsp_valid;
   rd_rsp_t       rd_rsp [n];
   logic [n-1:0]  wr_rsp_valid;
   wr_rsp_t       wr_rsp [n];
   addr_t         read_base         = 32'h1000_0000;  // read region
   addr_t         write_base        = 32'h8000_0000;  // write region
   host_rd_req_t  host_rd_req;
   logic          host_rd_en;
   logic          host_rd_sent      = 1'b0;
   host_wr_req_t  host_wr_req;
   logic          host_wr_en;
   logic          host_wr_sent      = 1'b0;
   logic          host_rd_rsp_valid = 1'b0;
   host_rd_rsp_t  host_rd_rsp       = '0;
   logic          host_wr_rsp_valid = 1'b0;
   host_wr_rsp_t  host_wr_rsp       = '0;

   // --------------------
   // model state
   // --------------------
   logic [31:0]   seed       = 32'hf154;
   int            errors     = 0;
   logic          stop_new   = 1'b0;                    // clients stop raising requests
   int            rd_acc_cnt = 0;
   int            wr_acc_cnt = 0;
   int            rd_done    = 0;                       // host read responses sent
   int            wr_done    = 0;
   tag_t          rd_tag [n] = '{default: '0};          // next local tag
   tag_t          wr_tag [n] = '{default: '0};
   int            rd_out [n] = '{default: 0};           // ids open at host
   int            wr_out [n] = '{default: 0};
   int            rd_wait [n] = '{default: 0};          // other grants while held
   int            wr_wait [n] = '{default: 0};
   tid_t          rd_pend_tid [$];                      // accepted, not answered
   addr_t         rd_pend_addr [$];
   tid_t          wr_pend_tid [$];
   addr_t         wr_pend_addr [$];
   client_id_t    exp_rd_cl   = '0;                     // expected client response
   tag_t          exp_rd_tag  = '0;
   addr_t         exp_rd_addr = '0;
   data_t         exp_rd_data = '0;
   client_id_t    exp_wr_cl   = '0;
   tag_t          exp_wr_tag  = '0;
   addr_t         exp_wr_addr = '0;
   client_id_t    chk_rd_cl   = '0;                     // lined up with client response
   tag_t          chk_rd_tag  = '0;
   addr_t         chk_rd_addr = '0;
   data_t         chk_rd_data = '0;
   client_id_t    chk_wr_cl   = '0;
   tag_t          chk_wr_tag  = '0;
   addr_t         chk_wr_addr = '0;

   client_id_t    rd_cl;                                // client named by host tid
   client_id_t    wr_cl;
   logic          rd_req_ok;
   logic          wr_req_ok;
   logic          rd_sent_ok;
   logic          wr_sent_ok;
   logic          rd_rsp_ok;
   logic          wr_rsp_ok;
   logic          idle_ok;
   logic          fair_ok;

   request_arbiter u_request_arbiter (.*);

   function automatic logic [31:0] draw();
      seed = seed * 32'd1664525 + 32'd1013904223;       // lcg step
      return {seed[15:0], seed[31:16]};                 // strong bits low
   endfunction

   task automatic log_failure(input string msg);
      errors++;
      $display("FAIL %0t: %s", $time, msg);
   endtask

   initial
   begin
      forever #20 Clk_32UI = ~Clk_32UI;                 // 40 ns period
   end

   // --------------------
   // expected values from the request and response rules
   // --------------------
   assign rd_cl = host_rd_req.tid[$bits(tid_t)-1 -: `ARB_CLIENT_W];
   assign wr_cl = host_wr_req.tid[$bits(tid_t)-1 -: `ARB_CLIENT_W];
   assign rd_req_ok = rd_en[rd_cl] && (host_rd_req.addr == read_base + rd_req[rd_cl].offset)
                      && (host_rd_req.tid[`ARB_TAG_W-1:0] == rd_req[rd_cl].tag);
   assign wr_req_ok = wr_en[wr_cl] && (host_wr_req.addr == write_base + wr_req[wr_cl].offset)
                      && (host_wr_req.tid[`ARB_TAG_W-1:0] == wr_req[wr_cl].tag)
                      && (host_wr_req.data == wr_req[wr_cl].data);
   assign rd_sent_ok = (host_rd_en == |rd_en)
                       && (rd_sent == ((host_rd_en && host_rd_sent) ? (lsb_one << rd_cl) : '0));
   assign wr_sent_ok = (host_wr_en == |wr_en)
                       && (wr_sent == ((host_wr_en && host_wr_sent) ? (lsb_one << wr_cl) : '0));
   assign rd_rsp_ok = (rd_rsp_valid == (lsb_one << chk_rd_cl))
                      && (rd_rsp[chk_rd_cl].tag == chk_rd_tag)
                      && (rd_rsp[chk_rd_cl].addr == chk_rd_addr)
                      && (rd_rsp[chk_rd_cl].data == chk_rd_data);
   assign wr_rsp_ok = (wr_rsp_valid == (lsb_one << chk_wr_cl))
                      && (wr_rsp[chk_wr_cl].tag == chk_wr_tag)
                      && (wr_rsp[chk_wr_cl].addr == chk_wr_addr);
   assign idle_ok = !host_rd_en && !host_wr_en && (rd_sent == '0) && (wr_sent == '0)
                    && (rd_rsp_valid == '0) && (wr_rsp_valid == '0);

   // client response trails the host pulse by one register stage
   always @(posedge Clk_32UI)
   begin
      chk_rd_cl   <= exp_rd_cl;
      chk_rd_tag  <= exp_rd_tag;
      chk_rd_addr <= exp_rd_addr;
      chk_rd_data <= exp_rd_data;
      chk_wr_cl   <= exp_wr_cl;
      chk_wr_tag  <= exp_wr_tag;
      chk_wr_addr <= exp_wr_addr;
   end

   always_comb
   begin
      fair_ok = 1'b1;
      for (int c = 0; c < n; c++)
      begin
         if (rd_wait[c] >= n || wr_wait[c] >= n)
            fair_ok = 1'b0;                             // passed over a full round
      end
   end

   // --------------------
   // checks
   // --------------------
   a_reset_idle : assert property (@(posedge Clk_32UI) $rose(reset_n) |-> idle_ok)
      else log_failure("host enables, sent bits or response valids not low after reset");
   a_rd_request : assert property (@(posedge Clk_32UI) disable iff (!reset_n)
      (host_rd_en && host_rd_sent) |-> rd_req_ok)
      else log_failure("accepted read address or tid differs from base plus offset");
   a_wr_request : assert property (@(posedge Clk_32UI) disable iff (!reset_n)
      (host_wr_en && host_wr_sent) |-> wr_req_ok)
      else log_failure("accepted write address, tid or data differs from client request");
   a_rd_sent : assert property (@(posedge Clk_32UI) disable iff (!reset_n) rd_sent_ok)
      else log_failure("rd_sent not matching the forwarded read client");
   a_wr_sent : assert property (@(posedge Clk_32UI) disable iff (!reset_n) wr_sent_ok)
      else log_failure("wr_sent not matching the forwarded write client");
   a_fairness : assert property (@(posedge Clk_32UI) disable iff (!reset_n) fair_ok)
      else log_failure("held request waited for more than one round of acceptances");
   a_rd_rsp : assert property (@(posedge Clk_32UI) disable iff (!reset_n)
      $past(host_rd_rsp_valid) ? rd_rsp_ok : (rd_rsp_valid == '0))
      else log_failure("read response valid, tag, address or data wrong");
   a_wr_rsp : assert property (@(posedge Clk_32UI) disable iff (!reset_n)
      $past(host_wr_rsp_valid) ? wr_rsp_ok : (wr_rsp_valid == '0))
      else log_failure("write response valid, tag or address wrong");

   // --------------------
   // client and host models
   // --------------------
   always @(posedge Clk_32UI)
   begin
      logic [31:0] r;
      int          i;
      tid_t        t;
      addr_t       a;
      if (reset_n)
      begin
         r = draw();
         host_rd_sent <= |r[1:0];                       // accept about 3 in 4
         host_wr_sent <= |r[3:2];
         if (host_rd_en && host_rd_sent)
            rd_acc_cnt <= rd_acc_cnt + 1;
         if (host_wr_en && host_wr_sent)
            wr_acc_cnt <= wr_acc_cnt + 1;
         for (int c = 0; c < n; c++)
         begin
            if (rd_en[c] && rd_sent[c])                 // read taken, record open id
            begin
               rd_en[c] <= 1'b0;
               rd_pend_tid.push_back({client_id_t'(c), rd_tag[c]});
               rd_pend_addr.push_back(read_base + rd_req[c].offset);
               rd_tag[c]++;
               rd_out[c]++;
               rd_wait[c] = 0;
            end
            else if (rd_en[c] && (|rd_sent))
               rd_wait[c]++;                            // another client went first
            else if (!rd_en[c] && !stop_new && rd_out[c] < max_out && draw() < 32'h6000_0000)
            begin
               rd_req[c].offset <= draw();
               rd_req[c].tag    <= rd_tag[c];
               rd_en[c]         <= 1'b1;
            end
            if (wr_en[c] && wr_sent[c])
            begin
               wr_en[c] <= 1'b0;
               wr_pend_tid.push_back({client_id_t'(c), wr_tag[c]});
               wr_pend_addr.push_back(write_base + wr_req[c].offset);
               wr_tag[c]++;
               wr_out[c]++;
               wr_wait[c] = 0;
            end
            else if (wr_en[c] && (|wr_sent))
               wr_wait[c]++;
            else if (!wr_en[c] && !stop_new && wr_out[c] < max_out && draw() < 32'h6000_0000)
            begin
               wr_req[c].offset <= draw();
               wr_req[c].tag    <= wr_tag[c];
               wr_req[c].data   <= data_t'({draw(), draw()});
               wr_en[c]         <= 1'b1;
            end
         end
         // host answers a random open id, out of order
         r = draw();
         host_rd_rsp_valid <= 1'b0;
         host_wr_rsp_valid <= 1'b0;
         if (rd_pend_tid.size() > 0 && r[0])
         begin
            i = int'(r[15:8]) % rd_pend_tid.size();
            t = rd_pend_tid[i];
            a = rd_pend_addr[i];
            host_rd_rsp_valid <= 1'b1;
            host_rd_rsp.tid   <= t;
            host_rd_rsp.data  <= data_t'(a) ^ data_t'(t);   // address xor tid
            exp_rd_cl   <= t[$bits(tid_t)-1 -: `ARB_CLIENT_W];
            exp_rd_tag  <= t[`ARB_TAG_W-1:0];
            exp_rd_addr <= a;
            exp_rd_data <= data_t'(a) ^ data_t'(t);
            rd_out[t[$bits(tid_t)-1 -: `ARB_CLIENT_W]]--;
            rd_done <= rd_done + 1;
            rd_pend_tid.delete(i);
            rd_pend_addr.delete(i);
         end
         if (wr_pend_tid.size() > 0 && r[1])
         begin
            i = int'(r[23:16]) % wr_pend_tid.size();
            t = wr_pend_tid[i];
            host_wr_rsp_valid <= 1'b1;
            host_wr_rsp.tid   <= t;
            exp_wr_cl   <= t[$bits(tid_t)-1 -: `ARB_CLIENT_W];
            exp_wr_tag  <= t[`ARB_TAG_W-1:0];
            exp_wr_addr <= wr_pend_addr[i];
            wr_out[t[$bits(tid_t)-1 -: `ARB_CLIENT_W]]--;
            wr_done <= wr_done + 1;
            wr_pend_tid.delete(i);
            wr_pend_addr.delete(i);
         end
      end
   end

   // --------------------
   // run control
   // --------------------
   initial
   begin
      int   cycles;
      logic timed_out;
      timed_out = 1'b0;
      repeat (2) @(posedge Clk_32UI);                  // reset for two cycles
      reset_n <= 1'b1;
      cycles = 0;
      while ((rd_done < num_rsp || wr_done < num_rsp) && cycles < run_limit)
      begin
         @(posedge Clk_32UI);
         cycles++;
      end
      if (cycles >= run_limit)
      begin
         timed_out = 1'b1;
         $display("timeout: host did not answer %0d reads and writes", num_rsp);
      end
      stop_new <= 1'b1;                                 // let held requests drain
      cycles = 0;
      while (!timed_out && cycles < run_limit && !(rd_en == '0 && wr_en == '0
             && rd_acc_cnt == rd_done && wr_acc_cnt == wr_done))
      begin
         @(posedge Clk_32UI);
         cycles++;
      end
      if (cycles >= run_limit)
      begin
         timed_out = 1'b1;
         $display("timeout: open requests never drained");
      end
      repeat (2) @(posedge Clk_32UI);                  // last response reaches its client
      $display("reads=%0d writes=%0d errors=%0d", rd_done, wr_done, errors);
      if (timed_out || errors != 0)
         $display("TEST RESULT: FAIL");
      else
         $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

// ==== list.f ====
+incdir+hw
hw/arb_pkg.sv
hw/fair_arbiter.sv
hw/read_path.sv
hw/write_path.sv
hw/response_router.sv
hw/request_arbiter.sv
verif/tb_request_arbiter.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps -f list.f \
   --top-module tb_request_arbiter -o tb_request_arbiter &&
./obj_dir/tb_request_arbiter | tee /dev/stderr | grep "TEST RESULT: PASS" > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
